/* Bender.yml */
package:
  name: umi_mem_subsys

sources:
  # Package and RTL, in compile order
  - files:
      - umi_pkg.sv
      - umi_loc_if.sv
      - umi_wait_timer.sv
      - umi_loc_mem.sv
      - umi_endpoint.sv
      - umi_mem_subsys.sv
  # Testbench, reads umi_trace.txt from the project root
  - target: test
    files:
      - umi_checker.sv
      - tb_umi_mem_subsys.sv

/* tb_umi_mem_subsys.sv */
//##############################
// Testbench for the UMI memory subsystem
// Replays umi_trace.txt on the request port under random
// response back-pressure, checking is done in umi_checker
//##############################
`timescale 1ns/1ps
`default_nettype none

module tb_umi_mem_subsys import umi_pkg::*; ();

   localparam int WAIT    = 2;
   localparam int DEPTH   = 64;
   localparam int RST_CYC = 16;         // Reset length in cycles
   localparam int TIMEOUT = 200;        // Cycles allowed per handshake wait

   logic              clk        = 1'b0;
   logic              nreset;
   logic              req_valid;
   logic [umi_cw-1:0] req_cmd;
   logic [umi_aw-1:0] req_dstaddr;
   logic [umi_aw-1:0] req_srcaddr;
   logic [umi_dw-1:0] req_data;
   logic              req_ready;
   logic              resp_valid;
   logic [umi_cw-1:0] resp_cmd;
   logic [umi_aw-1:0] resp_dstaddr;
   logic [umi_aw-1:0] resp_srcaddr;
   logic [umi_dw-1:0] resp_data;
   logic              resp_ready = 1'b1;
   logic [31:0]       rnd        = 32'hf2d1;   // Xorshift state
   logic [umi_dw-1:0] exp_data;                // Trace expectation, to checker
   int                chk_errors;
   int                chk_pending;
   int                timeouts     = 0;
   int                trace_errors = 0;

   // Trace columns, one entry per transaction
   logic [7:0]        t_op[$];
   logic [3:0]        t_size[$];
   logic [19:0]       t_opts[$];
   logic [umi_aw-1:0] t_dst[$];
   logic [umi_aw-1:0] t_src[$];
   logic [umi_dw-1:0] t_data[$];
   logic [umi_dw-1:0] t_exp[$];

   always #20 clk = ~clk;               // 40 ns period

   umi_mem_subsys #(
      .WAIT  (WAIT),
      .DEPTH (DEPTH)
   ) u_umi_mem_subsys (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready)
   );

   umi_checker #(
      .WAIT (WAIT)
   ) u_checker (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_srcaddr  (req_srcaddr),
      .req_ready    (req_ready),
      .exp_data     (exp_data),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .errors       (chk_errors),
      .pending      (chk_pending)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Host stalls about one cycle in three
   always @(posedge clk)
   begin
      rnd = xorshift32(rnd);
      resp_ready <= (rnd % 32'd3) != 32'd0;
   end

   //##############################
   // Trace input
   //##############################
   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      string       exp_str;
      logic [31:0] op, size, opts, dst, src;
      logic [63:0] data, exp;
      fd = $fopen("umi_trace.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the trace file umi_trace.txt");
         trace_errors++;
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.substr(0, 0) != "#")   // Skip comments and blanks
         begin
            exp = '0;
            n = $sscanf(line, "%h %h %h %h %h %h %s", op, size, opts, dst, src, data, exp_str);
            if (n != 7)
            begin
               $display("Malformed trace line: %s", line);
               trace_errors++;
            end
            else
            begin
               if (exp_str != "-")
                  n = $sscanf(exp_str, "%h", exp);   // Dash means no response
               t_op.push_back(op[7:0]);
               t_size.push_back(size[3:0]);
               t_opts.push_back(opts[19:0]);
               t_dst.push_back(dst);
               t_src.push_back(src);
               t_data.push_back(data);
               t_exp.push_back(exp);
            end
         end
      end
      $fclose(fd);
      if (t_op.size() == 0)
      begin
         $display("The trace file holds no transactions");
         trace_errors++;
      end
   endtask

   // Called just after a rising edge, returns just after the transfer edge
   task automatic send_request(input int i);
      int wait_cnt;
      req_valid   <= 1'b1;
      req_cmd     <= {t_opts[i], t_size[i], t_op[i]};
      req_dstaddr <= t_dst[i];
      req_srcaddr <= t_src[i];
      req_data    <= t_data[i];
      exp_data    <= t_exp[i];
      wait_cnt = 0;
      @(negedge clk);
      while (!req_ready && wait_cnt < TIMEOUT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!req_ready)
      begin
         $display("Timed out waiting for req_ready on trace entry %0d", i);
         timeouts++;
      end
      @(posedge clk);                   // Packet goes across here
   endtask

   //##############################
   // Main sequence
   //##############################
   initial
   begin
      int wait_cnt;
      int total;
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      exp_data    = '0;
      load_trace();
      repeat (RST_CYC) @(posedge clk);
      nreset <= 1'b1;
      repeat (2) @(posedge clk);        // Checker looks at idle outputs here
      for (int i = 0; i < t_op.size() && timeouts == 0; i++)
         send_request(i);
      req_valid <= 1'b0;
      // Drain the last response and let the endpoint go idle
      wait_cnt = 0;
      while ((chk_pending != 0 || !req_ready) && wait_cnt < TIMEOUT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (chk_pending != 0 || !req_ready)
      begin
         $display("Timed out waiting for outstanding responses to drain");
         timeouts++;
      end
      repeat (8) @(posedge clk);        // Window for stray responses
      total = chk_errors + timeouts + trace_errors + chk_pending;
      $display("Errors: %0d check, %0d timeout, %0d trace, %0d responses missing",
               chk_errors, timeouts, trace_errors, chk_pending);
      if (total == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* umi_checker.sv */
//##############################
// Response checker for the memory subsystem testbench
// Watches both device ports on the falling edge, queues the
// expected read responses and compares each response transfer
//##############################
`timescale 1ns/1ps
`default_nettype none

module umi_checker import umi_pkg::*;
  #(parameter int WAIT = 2)             // Memory wait states
  (
   input  logic              clk,
   input  logic              nreset,
   input  logic              req_valid,
   input  logic [umi_cw-1:0] req_cmd,
   input  logic [umi_aw-1:0] req_srcaddr,
   input  logic              req_ready,
   input  logic [umi_dw-1:0] exp_data,  // Trace value for the current request
   input  logic              resp_valid,
   input  logic [umi_cw-1:0] resp_cmd,
   input  logic [umi_aw-1:0] resp_dstaddr,
   input  logic [umi_aw-1:0] resp_srcaddr,
   input  logic [umi_dw-1:0] resp_data,
   input  logic              resp_ready,
   output int                errors,
   output int                pending    // Reads still owed a response
   );

   logic [umi_cw-1:0] cmd_q[$];         // Expected responses, oldest first
   logic [umi_aw-1:0] dst_q[$];
   logic [umi_dw-1:0] data_q[$];
   logic [umi_cw-1:0] hold_cmd;         // First cycle of a stalled response
   logic [umi_aw-1:0] hold_dst;
   logic [umi_dw-1:0] hold_data;
   logic              held       = 1'b0;   // Response waiting on the host
   logic              reset_seen = 1'b0;
   int                cyc        = 0;
   int                xfer_cyc   = 0;      // Cycle of the last read transfer
   int                err_cnt    = 0;
   int                pend_cnt   = 0;

   assign errors  = err_cnt;
   assign pending = pend_cnt;

   task automatic compare_field(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
         err_cnt++;
      end
   endtask

   always @(negedge clk)
   begin
      cyc++;
      if (nreset)
      begin
         if (!reset_seen)               // Idle outputs before any request
         begin
            compare_field("req_ready", 64'd1, 64'(req_ready));
            compare_field("resp_valid", 64'd0, 64'(resp_valid));
            reset_seen = 1'b1;
         end
         // Read goes across on the coming edge
         if (req_valid && req_ready && req_cmd[7:0] == UMI_REQ_READ)
         begin
            cmd_q.push_back({req_cmd[31:8], UMI_RESP_READ});   // Size and options kept
            dst_q.push_back(req_srcaddr);                     // Reply to the sender
            data_q.push_back(exp_data);
            pend_cnt++;
            xfer_cyc = cyc;
         end
         if (resp_valid && !held)
         begin
            // Set on edge WAIT+2 after the transfer, seen here one edge later
            if (cyc - xfer_cyc != WAIT + 3)
            begin
               $display("Fail at %0t: resp_valid latency expected %0d, got %0d",
                        $time, WAIT + 2, cyc - xfer_cyc - 1);
               err_cnt++;
            end
            hold_cmd  = resp_cmd;
            hold_dst  = resp_dstaddr;
            hold_data = resp_data;
         end
         else if (resp_valid)           // Stalled, fields must not move
         begin
            compare_field("resp_cmd (stalled)", 64'(hold_cmd), 64'(resp_cmd));
            compare_field("resp_dstaddr (stalled)", 64'(hold_dst), 64'(resp_dstaddr));
            compare_field("resp_data (stalled)", hold_data, resp_data);
         end
         if (resp_valid && resp_ready)
         begin
            if (cmd_q.size() == 0)
            begin
               $display("A response arrived at %0t with no read request outstanding", $time);
               err_cnt++;
            end
            else
            begin
               compare_field("resp_cmd", 64'(cmd_q.pop_front()), 64'(resp_cmd));
               compare_field("resp_dstaddr", 64'(dst_q.pop_front()), 64'(resp_dstaddr));
               compare_field("resp_srcaddr", 64'd0, 64'(resp_srcaddr));
               compare_field("resp_data", data_q.pop_front(), resp_data);
               pend_cnt--;
            end
         end
         held = resp_valid && !resp_ready;
      end
   end

endmodule

`default_nettype wire

/* umi_endpoint.sv */
//############################
// UMI device endpoint, one transaction at a time
// Accepts read and write requests, runs them on the local bus
// Reads return a registered response, writes are posted
//############################
`timescale 1ns/1ps
`default_nettype none

module umi_endpoint import umi_pkg::*;
  (
   input  logic              clk,
   input  logic              nreset,
   // Device request
   input  logic              req_valid,
   input  logic [umi_cw-1:0] req_cmd,
   input  logic [umi_aw-1:0] req_dstaddr,
   input  logic [umi_aw-1:0] req_srcaddr,
   input  logic [umi_dw-1:0] req_data,
   output logic              req_ready,
   // Device response
   output logic              resp_valid,
   output logic [umi_cw-1:0] resp_cmd,
   output logic [umi_aw-1:0] resp_dstaddr,
   output logic [umi_aw-1:0] resp_srcaddr,
   output logic [umi_dw-1:0] resp_data,
   input  logic              resp_ready,
   // Local memory bus
   umi_loc_if.ep             loc
   );

   umi_ep_state_e     state;
   umi_opcode_e       req_op;           // Decoded request opcode
   logic              req_xfer;         // Packet taken this cycle
   logic              req_known;        // Read or write, else dropped
   logic              loc_done;         // Local access completes
   logic [3:0]        req_size;
   logic [2:0]        req_off;          // Aligned byte offset
   logic [3:0]        size_q;           // Held for the read data path
   logic [2:0]        off_q;
   logic [7:0]        rd_strobe;        // Low lanes kept on a read
   logic [umi_dw-1:0] rd_mask;
   logic [umi_dw-1:0] rd_shift;

   //############################
   // Handshakes and decode
   //############################
   assign req_ready    = (state == ST_IDLE);
   assign resp_valid   = (state == ST_RESP);
   assign resp_srcaddr = '0;            // Responses carry no source
   assign req_xfer     = req_valid & req_ready;
   assign loc_done     = loc.req & loc.ready;

   assign req_op    = umi_opcode_e'(cmd_opcode(req_cmd));
   assign req_known = (req_op == UMI_REQ_READ) || (req_op == UMI_REQ_WRITE);
   assign req_size  = cmd_size(req_cmd);
   assign req_off   = size_offset(req_size, req_dstaddr[2:0]);

   //############################
   // Transaction FSM
   //############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state   <= ST_IDLE;
         loc.req <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (req_xfer && req_known)
                  state <= ST_ACCESS;   // Undefined opcodes stay here
            ST_ACCESS:
               if (!loc.req)
                  loc.req <= 1'b1;      // Issue one cycle after capture
               else if (loc_done)
               begin
                  loc.req <= 1'b0;
                  state   <= loc.write ? ST_IDLE : ST_RESP;
               end
            ST_RESP:
               if (resp_ready)
                  state <= ST_IDLE;     // Response taken by the host
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   //############################
   // Request capture and read data
   //############################
   always_ff @(posedge clk)
   begin
      if (req_xfer)
      begin
         loc.write <= (req_op == UMI_REQ_WRITE);
         loc.addr  <= {3'b000, req_dstaddr[umi_aw-1:3]};   // Word address
         loc.wstrb <= size_strobe(req_size, req_dstaddr[2:0]);
         loc.wdata <= req_data << {req_off, 3'b000};       // Onto target lanes
         size_q    <= req_size;
         off_q     <= req_off;
      end
      // Response header only changes while no response is pending
      if (req_xfer && (req_op == UMI_REQ_READ))
      begin
         resp_cmd     <= cmd_pack(UMI_RESP_READ, req_size, cmd_options(req_cmd));
         resp_dstaddr <= req_srcaddr;   // Reply goes back to the sender
      end
      if (loc_done && !loc.write)
         resp_data <= rd_shift & rd_mask;
   end

   // Selected bytes down to lane 0, upper lanes zero
   assign rd_shift  = loc.rdata >> {off_q, 3'b000};
   assign rd_strobe = size_strobe(size_q, 3'd0);

   always_comb
   begin
      for (int i = 0; i < umi_dw/8; i++)
         rd_mask[8*i +: 8] = {8{rd_strobe[i]}};
   end

endmodule

`default_nettype wire

/* umi_loc_if.sv */
//############################
// Local memory bus between the endpoint and the memory
// Endpoint holds req and fields until req and ready meet
//############################
`timescale 1ns/1ps
`default_nettype none

interface umi_loc_if import umi_pkg::*; ();

   logic                  req;          // Access request
   logic                  write;        // 1 write, 0 read
   logic [umi_aw-1:0]     addr;         // Word address
   logic [umi_dw/8-1:0]   wstrb;        // Byte lanes to write
   logic [umi_dw-1:0]     wdata;        // Lane aligned write data
   logic [umi_dw-1:0]     rdata;        // Addressed word
   logic                  ready;        // Access completes this cycle

   // Endpoint side
   modport ep (
      output req, write, addr, wstrb, wdata,
      input  rdata, ready
   );

   // Memory side
   modport mem (
      input  req, write, addr, wstrb, wdata,
      output rdata, ready
   );

endinterface

`default_nettype wire

/* umi_loc_mem.sv */
//############################
// Byte strobed word memory behind the local bus
// WAIT sets the access latency, DEPTH the word count
//############################
`timescale 1ns/1ps
`default_nettype none

module umi_loc_mem import umi_pkg::*;
  #(parameter int WAIT  = 2,            // Wait states per access
    parameter int DEPTH = 64)           // Words, power of two
  (
   input  logic    clk,
   input  logic    nreset,
   umi_loc_if.mem  loc
   );

   localparam int IDX_W = $clog2(DEPTH);
   localparam int LANES = umi_dw/8;

   logic [umi_dw-1:0] mem [DEPTH];      // Storage, not reset
   logic [IDX_W-1:0]  idx;              // Word index
   logic              done;             // Wait states elapsed
   logic              wr_en;

   //############################
   // Access timing
   //############################
   umi_wait_timer #(
      .WAIT (WAIT)
   ) u_wait_timer (
      .clk    (clk),
      .nreset (nreset),
      .access (loc.req),
      .done   (done)
   );

   assign loc.ready = done;

   //############################
   // Storage
   //############################
   // Upper address bits wrap
   assign idx   = loc.addr[IDX_W-1:0];
   assign wr_en = loc.req & done & loc.write;   // Completing edge only

   // Byte lanes under strobe, others keep their contents
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         for (int b = 0; b < LANES; b++)
         begin
            if (loc.wstrb[b])
               mem[idx][8*b +: 8] <= loc.wdata[8*b +: 8];
         end
      end
   end

   // Read word valid while ready is high
   assign loc.rdata = done ? mem[idx] : '0;

endmodule

`default_nettype wire

/* umi_mem_subsys.f */
umi_pkg.sv
umi_loc_if.sv
umi_wait_timer.sv
umi_loc_mem.sv
umi_endpoint.sv
umi_mem_subsys.sv
umi_checker.sv
tb_umi_mem_subsys.sv

/* umi_mem_subsys.sv */
//############################
// Memory subsystem top level
// UMI device request and response ports as plain ports
// Endpoint and wait state memory joined by the local bus
//############################
`timescale 1ns/1ps
`default_nettype none

module umi_mem_subsys import umi_pkg::*;
  #(parameter int WAIT  = 2,            // Memory wait states
    parameter int DEPTH = 64)           // Memory words
  (
   input  logic              clk,
   input  logic              nreset,
   // Request from host
   input  logic              req_valid,
   input  logic [umi_cw-1:0] req_cmd,
   input  logic [umi_aw-1:0] req_dstaddr,
   input  logic [umi_aw-1:0] req_srcaddr,
   input  logic [umi_dw-1:0] req_data,
   output logic              req_ready,
   // Response to host
   output logic              resp_valid,
   output logic [umi_cw-1:0] resp_cmd,
   output logic [umi_aw-1:0] resp_dstaddr,
   output logic [umi_aw-1:0] resp_srcaddr,
   output logic [umi_dw-1:0] resp_data,
   input  logic              resp_ready
   );

   umi_loc_if u_loc_if ();              // Local memory bus

   umi_endpoint u_umi_endpoint (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .loc          (u_loc_if.ep)
   );

   umi_loc_mem #(
      .WAIT  (WAIT),
      .DEPTH (DEPTH)
   ) u_umi_loc_mem (
      .clk    (clk),
      .nreset (nreset),
      .loc    (u_loc_if.mem)
   );

endmodule

`default_nettype wire

/* umi_pkg.sv */
//############################
// Shared UMI definitions for the memory subsystem
// Widths, command layout, opcodes, endpoint states and helpers
// Import with a wildcard in the module header
//############################
`default_nettype none

package umi_pkg;

   parameter int umi_cw = 32;           // Command word
   parameter int umi_aw = 32;           // Dst and src address
   parameter int umi_dw = 64;           // One data word per packet

   // Command opcodes, bits 7 to 0 of the command word
   typedef enum logic [7:0] {
      UMI_REQ_READ  = 8'h02,
      UMI_REQ_WRITE = 8'h04,
      UMI_RESP_READ = 8'h08
   } umi_opcode_e;

   // Endpoint transaction states
   typedef enum logic [1:0] {
      ST_IDLE,                          // Waiting for a request
      ST_ACCESS,                        // Local bus access in flight
      ST_RESP                           // Read response held for the host
   } umi_ep_state_e;

   //############################
   // Command field helpers
   //############################
   function automatic logic [7:0] cmd_opcode(input logic [umi_cw-1:0] cmd);
      return cmd[7:0];
   endfunction

   function automatic logic [3:0] cmd_size(input logic [umi_cw-1:0] cmd);
      return cmd[11:8];                 // log2 of byte count
   endfunction

   function automatic logic [19:0] cmd_options(input logic [umi_cw-1:0] cmd);
      return cmd[31:12];
   endfunction

   function automatic logic [umi_cw-1:0] cmd_pack(input logic [7:0]  opcode,
                                                  input logic [3:0]  size,
                                                  input logic [19:0] options);
      return {options, size, opcode};
   endfunction

   //############################
   // Byte lane helpers
   //############################
   // Offset with the low size bits cleared
   function automatic logic [2:0] size_offset(input logic [3:0] size,
                                              input logic [2:0] offset);
      case (size)
         4'd0:    return offset;
         4'd1:    return {offset[2:1], 1'b0};
         4'd2:    return {offset[2], 2'b00};
         default: return 3'd0;          // Full word
      endcase
   endfunction

   function automatic logic [7:0] size_strobe(input logic [3:0] size,
                                              input logic [2:0] offset);
      logic [7:0] base;
      case (size)
         4'd0:    base = 8'h01;
         4'd1:    base = 8'h03;
         4'd2:    base = 8'h0f;
         default: base = 8'hff;
      endcase
      return base << size_offset(size, offset);
   endfunction

endpackage

`default_nettype wire

/* umi_trace.txt */
# opcode size options dstaddr srcaddr data expected_resp_data, all hex
# a dash in the last column means no response is expected
04 3 00000 00000100 00001000 0123456789abcdef -
02 3 00abc 00000100 00001004 0000000000000000 0123456789abcdef
04 0 00001 00000103 00001008 000000000000005a -
04 1 00002 00000106 0000100c 111122223333beef -
04 3 00003 00000108 00001010 8877665544332211 -
04 2 00004 0000010c 00001014 99999999cafef00d -
02 3 12345 00000100 00002000 0000000000000000 beef45675aabcdef
02 3 fffff 00000108 00002004 0000000000000000 cafef00d44332211
02 0 00010 00000103 00002008 0000000000000000 000000000000005a
02 1 00020 00000107 0000200c 0000000000000000 000000000000beef
02 2 00030 0000010e 00002010 0000000000000000 00000000cafef00d
02 0 00040 00000109 00002014 0000000000000000 0000000000000022
06 3 00000 00000100 00003000 ffffffffffffffff -
02 3 00050 00000100 00003004 0000000000000000 beef45675aabcdef
08 3 00000 00000108 00003008 0000000000000000 -
02 3 00060 00000108 0000300c 0000000000000000 cafef00d44332211
04 3 00007 00000300 00003010 a5a5a5a55a5a5a5a -
02 3 00070 00000100 00003014 0000000000000000 a5a5a5a55a5a5a5a
04 3 00008 00000200 00004000 0f1e2d3c4b5a6978 -
02 3 00080 00000200 00004004 0000000000000000 0f1e2d3c4b5a6978
02 1 00090 00000202 00004008 0000000000000000 0000000000004b5a
02 2 000a0 00000204 0000400c 0000000000000000 000000000f1e2d3c
02 0 000b0 00000207 00004010 0000000000000000 000000000000000f
02 0 000c0 00000200 00004014 0000000000000000 0000000000000078
04 1 00009 000001f8 00004018 000000000000abcd -
02 1 000d0 000001f9 0000401c 0000000000000000 000000000000abcd
02 3 000e0 00000108 00005000 0000000000000000 cafef00d44332211
02 2 000f0 00000100 00005004 0000000000000000 000000005a5a5a5a

/* umi_wait_timer.sv */
//############################
// Wait state timer for the local memory
// Done rises WAIT cycles into an access and stays until it completes
//############################
`timescale 1ns/1ps
`default_nettype none

module umi_wait_timer
  #(parameter int WAIT = 2)             // 0 to 15
  (
   input  logic clk,
   input  logic nreset,
   input  logic access,                 // Held high through the access
   output logic done                    // Access may complete
   );

   localparam logic [3:0] WAIT_LD = 4'(WAIT);

   logic [3:0] cnt;                     // Wait states still to go

   //############################
   // Down counter
   //############################
   // Sits at WAIT while idle, so the first access cycle counts
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         cnt <= WAIT_LD;
      else if (access && done)
         cnt <= WAIT_LD;                // Reload for the next access
      else if (access)
         cnt <= cnt - 4'd1;             // Nonzero here, done is low
   end

   // Zero wait states give done in the first cycle
   assign done = access && (cnt == 4'd0);

endmodule

`default_nettype wire
